//--- verilog/sram_share_consts.svh
// Shared SRAM sizing
// Byte address, bridge word address and RAM depth
`ifndef SRAM_SHARE_CONSTS_SVH
`define SRAM_SHARE_CONSTS_SVH

// Byte address into the shared RAM
`define SRAM_SHARE_ADDR_W 13

// Bridge word address, two bits short of the byte address
`define SRAM_SHARE_WADR_W 11

// RAM depth in bytes
`define SRAM_SHARE_DEPTH 8192

`endif

//--- verilog/sram_share_pkg.sv
// Shared SRAM types
// Bridge request, RAM port structs and the lane select decode
`default_nettype none

`include "sram_share_consts.svh"

package sram_share_pkg;

   // One data word, whole or as byte lanes (lane 0 is bits 7:0)
   typedef union packed {
      logic [31:0]     word;
      logic [3:0][7:0] lane;
   } word_u;

   typedef struct packed {
      logic [`SRAM_SHARE_WADR_W-1:0] adr;
      word_u                         dat;
      logic [3:0]                    sel;
      logic                          we;
   } brg_req_t;

   typedef struct packed {
      logic                         en;
      logic [`SRAM_SHARE_ADDR_W-1:0] adr;
      logic [7:0]                   dat;
   } ram_wr_t;

   typedef struct packed {
      logic                         en;
      logic [`SRAM_SHARE_ADDR_W-1:0] adr;
   } ram_rd_t;

   // Decoded lane select, lane is the first lane to touch
   typedef struct packed {
      logic       valid;
      logic       full;
      logic [1:0] lane;
   } sel_dec_t;

   // Sel bit 3 is lane 0, bit 0 is lane 3
   function automatic sel_dec_t decode_sel(input logic [3:0] sel);
      sel_dec_t d;
      d = '0;
      case (sel)
         4'b1000: d = '{valid: 1'b1, full: 1'b0, lane: 2'd0};
         4'b0100: d = '{valid: 1'b1, full: 1'b0, lane: 2'd1};
         4'b0010: d = '{valid: 1'b1, full: 1'b0, lane: 2'd2};
         4'b0001: d = '{valid: 1'b1, full: 1'b0, lane: 2'd3};
         4'b1111: d = '{valid: 1'b1, full: 1'b1, lane: 2'd0};
         // Other patterns stay invalid and are never served
         default: d = '0;
      endcase
      return d;
   endfunction

endpackage

`default_nettype wire

//--- verilog/byte_ram.sv
// Shared byte RAM
// One write and one read port, read data registered one cycle later
`timescale 1ns/1ps
`default_nettype none

`include "sram_share_consts.svh"

module byte_ram (
   input  wire                     i_clk,
   input  wire sram_share_pkg::ram_wr_t i_wr,
   input  wire sram_share_pkg::ram_rd_t i_rd,
   output logic [7:0]              o_rdata
);

   logic [7:0] mem [`SRAM_SHARE_DEPTH];

   always_ff @(posedge i_clk) begin
      if (i_wr.en) begin
         mem[i_wr.adr] <= i_wr.dat;
      end
      // Output holds between reads
      if (i_rd.en) begin
         o_rdata <= mem[i_rd.adr];
      end
   end

   // Read-during-write to one byte is undefined, users must keep apart
   a_no_rw_collision: assert property (@(posedge i_clk)
      i_wr.en && i_rd.en |-> i_wr.adr != i_rd.adr)
      else $error("byte_ram: read and write to %h in one cycle", i_wr.adr);

endmodule

`default_nettype wire

//--- verilog/brg_write_slicer.sv
// Bridge write slicer
// Turns a bridge word write into one or four byte writes on the RAM
`timescale 1ns/1ps
`default_nettype none

module brg_write_slicer (
   input  wire                          i_clk,
   input  wire                          i_rst,
   input  wire                          i_go,
   input  wire sram_share_pkg::brg_req_t i_req,
   output sram_share_pkg::ram_wr_t      o_wr,
   output logic                         o_wr_done
);
   import sram_share_pkg::*;

   sel_dec_t   dec;
   logic       start;
   logic       busy;
   logic [1:0] lane_cnt;
   logic [1:0] cur_lane;

   assign dec = decode_sel(i_req.sel);

   // Held strobe is not taken again in the done cycle
   assign start = i_go && i_req.we && dec.valid && !busy && !o_wr_done;

   // Single lane comes from the decode, full word from the counter
   assign cur_lane = busy ? lane_cnt : dec.lane;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         busy      <= 1'b0;
         lane_cnt  <= 2'd0;
         o_wr.en   <= 1'b0;
         o_wr_done <= 1'b0;
      end else begin
         o_wr.en   <= start || busy;
         o_wr_done <= start && !dec.full;

         if (start || busy) begin
            o_wr.adr <= {i_req.adr, cur_lane};
            o_wr.dat <= i_req.dat.lane[cur_lane];
         end

         if (start && dec.full) begin
            // Lane 0 goes out now, lanes 1 to 3 follow
            busy     <= 1'b1;
            lane_cnt <= 2'd1;
         end else if (busy) begin
            lane_cnt <= lane_cnt + 2'd1;
            if (lane_cnt == 2'd3) begin
               busy      <= 1'b0;
               o_wr_done <= 1'b1;
            end
         end
      end
   end

   // One done per request, so never two in a row
   a_done_single: assert property (@(posedge i_clk) disable iff (i_rst)
      o_wr_done |=> !o_wr_done)
      else $error("brg_write_slicer: done held for two cycles");

endmodule

`default_nettype wire

//--- verilog/brg_read_gather.sv
// Bridge read gather
// Issues byte reads for a bridge read and collects them into one word
`timescale 1ns/1ps
`default_nettype none

module brg_read_gather (
   input  wire                          i_clk,
   input  wire                          i_rst,
   input  wire                          i_go,
   input  wire sram_share_pkg::brg_req_t i_req,
   input  wire [7:0]                    i_rdata,
   output sram_share_pkg::ram_rd_t      o_rd,
   output sram_share_pkg::word_u        o_rd_word,
   output logic                         o_rd_done
);
   import sram_share_pkg::*;

   sel_dec_t   dec;
   logic       start;
   logic       rd_last;
   logic       ret_vld;
   logic [1:0] ret_lane;
   word_u      word_q;

   assign dec = decode_sel(i_req.sel);

   // No new request while reads are out or in the done cycle
   assign start = i_go && !i_req.we && dec.valid && !o_rd.en && !o_rd_done;

   // Low address bits of the issued read are the lane
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_rd.en   <= 1'b0;
         rd_last   <= 1'b0;
         ret_vld   <= 1'b0;
         o_rd_done <= 1'b0;
      end else begin
         // Return tracking runs one cycle behind the issued read
         ret_vld   <= o_rd.en;
         ret_lane  <= o_rd.adr[1:0];
         o_rd_done <= o_rd.en && rd_last;

         if (start) begin
            o_rd.en  <= 1'b1;
            o_rd.adr <= {i_req.adr, dec.lane};
            rd_last  <= !dec.full;
         end else if (o_rd.en && !rd_last) begin
            o_rd.adr[1:0] <= o_rd.adr[1:0] + 2'd1;
            rd_last       <= (o_rd.adr[1:0] == 2'd2);
         end else begin
            o_rd.en <= 1'b0;
         end
      end
   end

   // Word under assembly with unselected lanes starting at zero
   always_ff @(posedge i_clk) begin
      if (start) begin
         word_q <= '0;
      end else if (ret_vld) begin
         word_q.lane[ret_lane] <= i_rdata;
      end
   end

   // Last byte is merged straight from the RAM so the word is
   // complete in the done cycle
   always_comb begin
      o_rd_word = word_q;
      if (ret_vld) begin
         o_rd_word.lane[ret_lane] = i_rdata;
      end
   end

   // Done comes with the return of the last lane of the request
   a_done_after_read: assert property (@(posedge i_clk) disable iff (i_rst)
      o_rd_done |-> ret_vld && ret_lane == (dec.full ? 2'd3 : dec.lane))
      else $error("brg_read_gather: done without a final read");

endmodule

`default_nettype wire

//--- verilog/ram_port_arbiter.sv
// RAM port arbiter
// Picks bridge engines or local port for the RAM by mode, steers read
// data back and forms the bridge acknowledge
`timescale 1ns/1ps
`default_nettype none

module ram_port_arbiter (
   input  wire                         i_clk,
   input  wire                         i_rst,
   input  wire                         i_brg_mode,
   input  wire                         i_brg_stb,
   output logic                        o_go,
   input  wire sram_share_pkg::ram_wr_t i_eng_wr,
   input  wire sram_share_pkg::ram_rd_t i_eng_rd,
   input  wire sram_share_pkg::ram_wr_t i_loc_wr,
   input  wire sram_share_pkg::ram_rd_t i_loc_rd,
   output sram_share_pkg::ram_wr_t     o_ram_wr,
   output sram_share_pkg::ram_rd_t     o_ram_rd,
   input  wire [7:0]                   i_ram_rdata,
   output logic [7:0]                  o_eng_rdata,
   output logic [7:0]                  o_loc_rdata,
   input  wire                         i_wr_done,
   input  wire                         i_rd_done,
   input  wire sram_share_pkg::word_u   i_rd_word,
   output logic                        o_brg_ack,
   output logic [31:0]                 o_brg_rdt
);

   logic [31:0] rdt_q;

   // Bridge strobes are dropped entirely in local mode
   assign o_go = i_brg_mode && i_brg_stb;

   assign o_ram_wr = i_brg_mode ? i_eng_wr : i_loc_wr;
   assign o_ram_rd = i_brg_mode ? i_eng_rd : i_loc_rd;

   // Inactive user sees zero
   assign o_eng_rdata = i_brg_mode ? i_ram_rdata : 8'h00;
   assign o_loc_rdata = i_brg_mode ? 8'h00 : i_ram_rdata;

   assign o_brg_ack = i_wr_done || i_rd_done;

   // Last gathered word, kept for the bridge after the ack
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         rdt_q <= '0;
      end else if (i_rd_done) begin
         rdt_q <= i_rd_word.word;
      end
   end

   // New word is visible together with the ack
   assign o_brg_rdt = i_rd_done ? i_rd_word.word : rdt_q;

   // Engines never finish in the same cycle
   a_one_done: assert property (@(posedge i_clk) disable iff (i_rst)
      !(i_wr_done && i_rd_done))
      else $error("ram_port_arbiter: write and read done together");

endmodule

`default_nettype wire

//--- verilog/sram_share_top.sv
// Shared SRAM top
// Bridge write and read engines and the local port on one byte RAM
`timescale 1ns/1ps
`default_nettype none

module sram_share_top (
   input  wire                          i_clk,
   input  wire                          i_rst,
   input  wire                          i_brg_mode,
   input  wire                          i_brg_stb,
   input  wire sram_share_pkg::brg_req_t i_brg_req,
   output logic                         o_brg_ack,
   output logic [31:0]                  o_brg_rdt,
   input  wire sram_share_pkg::ram_wr_t  i_loc_wr,
   input  wire sram_share_pkg::ram_rd_t  i_loc_rd,
   output logic [7:0]                   o_loc_rdata
);
   import sram_share_pkg::*;

   logic       go;
   ram_wr_t    eng_wr;
   ram_rd_t    eng_rd;
   ram_wr_t    ram_wr;
   ram_rd_t    ram_rd;
   logic [7:0] ram_rdata;
   logic [7:0] eng_rdata;
   logic       wr_done;
   logic       rd_done;
   word_u      rd_word;

   brg_write_slicer u_write_slicer (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_go      (go),
      .i_req     (i_brg_req),
      .o_wr      (eng_wr),
      .o_wr_done (wr_done)
   );

   brg_read_gather u_read_gather (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_go      (go),
      .i_req     (i_brg_req),
      .i_rdata   (eng_rdata),
      .o_rd      (eng_rd),
      .o_rd_word (rd_word),
      .o_rd_done (rd_done)
   );

   ram_port_arbiter u_arbiter (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_brg_mode  (i_brg_mode),
      .i_brg_stb   (i_brg_stb),
      .o_go        (go),
      .i_eng_wr    (eng_wr),
      .i_eng_rd    (eng_rd),
      .i_loc_wr    (i_loc_wr),
      .i_loc_rd    (i_loc_rd),
      .o_ram_wr    (ram_wr),
      .o_ram_rd    (ram_rd),
      .i_ram_rdata (ram_rdata),
      .o_eng_rdata (eng_rdata),
      .o_loc_rdata (o_loc_rdata),
      .i_wr_done   (wr_done),
      .i_rd_done   (rd_done),
      .i_rd_word   (rd_word),
      .o_brg_ack   (o_brg_ack),
      .o_brg_rdt   (o_brg_rdt)
   );

   byte_ram u_ram (
      .i_clk   (i_clk),
      .i_wr    (ram_wr),
      .i_rd    (ram_rd),
      .o_rdata (ram_rdata)
   );

endmodule

`default_nettype wire

//--- test/tb_sram_share.sv
// Testbench for the shared SRAM subsystem
// Random local and bridge traffic checked against a byte-array model
`timescale 1ns/1ps
`default_nettype none

`include "sram_share_consts.svh"

module tb_sram_share;
   import sram_share_pkg::*;

   localparam int CLK_PERIOD = 10;
   localparam int WORDS      = 1 << `SRAM_SHARE_WADR_W;
   localparam int N_RD       = 512;
   localparam int N_BRG      = 64;
   localparam int N_GATE     = 16;
   // Every operation is allowed 10 cycles, local reads of checked bytes included
   localparam int N_OPS      = `SRAM_SHARE_DEPTH + N_RD + N_BRG * 5 + N_BRG * 5
                               + N_BRG + N_GATE * 5 + N_BRG;
   localparam int WD_CYCLES  = N_OPS * 10 + 100;

   logic        i_clk = 1'b0;
   logic        i_rst;
   logic        i_brg_mode;
   logic        i_brg_stb;
   brg_req_t    i_brg_req;
   logic        o_brg_ack;
   logic [31:0] o_brg_rdt;
   ram_wr_t     i_loc_wr;
   ram_rd_t     i_loc_rd;
   logic [7:0]  o_loc_rdata;

   logic [7:0]  model [`SRAM_SHARE_DEPTH];
   int          checks;
   int          errors;
   int          tests_ok;
   int          test_err0;

   sram_share_top u_sram_share_top (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_brg_mode  (i_brg_mode),
      .i_brg_stb   (i_brg_stb),
      .i_brg_req   (i_brg_req),
      .o_brg_ack   (o_brg_ack),
      .o_brg_rdt   (o_brg_rdt),
      .i_loc_wr    (i_loc_wr),
      .i_loc_rd    (i_loc_rd),
      .o_loc_rdata (o_loc_rdata)
   );

   always #(CLK_PERIOD / 2) i_clk = ~i_clk;

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // One lane, or all four lanes when single is not forced
   function automatic logic [3:0] rand_sel(input bit single_only);
      int r;
      r = single_only ? $urandom % 4 : $urandom % 5;
      return (r == 4) ? 4'b1111 : (4'b1000 >> r);
   endfunction

   function automatic brg_req_t rand_req(input logic we, input logic [3:0] sel);
      brg_req_t r;
      r.adr      = $urandom % WORDS;
      r.dat.word = $urandom;
      r.sel      = sel;
      r.we       = we;
      return r;
   endfunction

   // Cycles from the edge that takes the strobe to the acked edge
   function automatic int exp_latency(input logic we, input logic [3:0] sel);
      if (we) begin
         return (sel == 4'b1111) ? 4 : 1;
      end
      return (sel == 4'b1111) ? 5 : 2;
   endfunction

   // Lane k is data bits 8k+7:8k at byte 4a+k, selected by sel bit 3-k
   function automatic logic [31:0] model_word(input int wadr, input logic [3:0] sel);
      logic [31:0] w;
      w = '0;
      for (int k = 0; k < 4; k++) begin
         if (sel[3-k]) begin
            w[8*k +: 8] = model[wadr * 4 + k];
         end
      end
      return w;
   endfunction

   task automatic model_write(input brg_req_t req);
      for (int k = 0; k < 4; k++) begin
         if (req.sel[3-k]) begin
            model[int'(req.adr) * 4 + k] = req.dat.word[8*k +: 8];
         end
      end
   endtask

   task automatic local_write(input int adr, input logic [7:0] dat);
      i_loc_wr.en  = 1'b1;
      i_loc_wr.adr = adr;
      i_loc_wr.dat = dat;
      @(posedge i_clk);
      #1;
      i_loc_wr.en = 1'b0;
      model[adr]  = dat;
   endtask

   // Data shows up one cycle after the address
   task automatic local_check(input int adr);
      i_loc_rd.en  = 1'b1;
      i_loc_rd.adr = adr;
      @(posedge i_clk);
      #1;
      i_loc_rd.en = 1'b0;
      check("o_loc_rdata", o_loc_rdata, model[adr]);
   endtask

   task automatic word_check(input int wadr);
      for (int k = 0; k < 4; k++) begin
         local_check(wadr * 4 + k);
      end
   endtask

   // Holds the strobe until ack or limit, then idles two cycles
   task automatic bridge_op(input brg_req_t req, input int limit, output bit got,
                            output int lat, output logic [31:0] rdt);
      i_brg_req = req;
      i_brg_stb = 1'b1;
      got = 1'b0;
      lat = 0;
      while (!got && lat < limit) begin
         @(posedge i_clk);
         #1;
         lat++;
         got = o_brg_ack;
      end
      i_brg_stb = 1'b0;
      rdt = o_brg_rdt;
      repeat (2) begin
         @(posedge i_clk);
         #1;
      end
   endtask

   task automatic bridge_do(input brg_req_t req, input int limit, output int lat,
                            output logic [31:0] rdt);
      bit got;
      bridge_op(req, limit, got, lat, rdt);
      if (!got) begin
         errors++;
         $display("No acknowledge within %0d cycles for word %h", limit, req.adr);
      end
   endtask

   task automatic end_test(input int num, input string name);
      int n;
      n = errors - test_err0;
      if (n == 0) begin
         tests_ok++;
      end
      $display("[%0d] %s: %s (%0d errors)", num, name, (n == 0) ? "ok" : "errors", n);
      test_err0 = errors;
   endtask

   initial begin
      #(WD_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles, run stopped", WD_CYCLES);
      $display("test failed");
      $finish;
   end

   initial begin
      brg_req_t    req;
      int          lat;
      logic [31:0] rdt;
      bit          got;
      int          wq[$];

      void'($urandom(32'h964f));
      i_rst      = 1'b1;
      i_brg_mode = 1'b0;
      i_brg_stb  = 1'b0;
      i_brg_req  = '0;
      i_loc_wr   = '0;
      i_loc_rd   = '0;
      checks     = 0;
      errors     = 0;
      tests_ok   = 0;
      test_err0  = 0;
      repeat (10) @(posedge i_clk);
      #1;
      i_rst = 1'b0;

      for (int a = 0; a < `SRAM_SHARE_DEPTH; a++) begin
         local_write(a, $urandom);
      end
      for (int i = 0; i < N_RD; i++) begin
         local_check($urandom % `SRAM_SHARE_DEPTH);
      end
      end_test(1, "local fill and readback");

      i_brg_mode = 1'b1;
      for (int i = 0; i < N_BRG; i++) begin
         req = rand_req(1'b1, 4'b1111);
         bridge_do(req, 10, lat, rdt);
         model_write(req);
         wq.push_back(req.adr);
      end
      i_brg_mode = 1'b0;
      foreach (wq[i]) begin
         word_check(wq[i]);
      end
      end_test(2, "bridge full-word write");

      for (int i = 0; i < N_BRG; i++) begin
         i_brg_mode = 1'b1;
         req = rand_req(1'b1, rand_sel(1'b1));
         bridge_do(req, 10, lat, rdt);
         model_write(req);
         i_brg_mode = 1'b0;
         word_check(req.adr);
      end
      end_test(3, "bridge single-lane write");

      i_brg_mode = 1'b1;
      for (int i = 0; i < N_BRG; i++) begin
         req = rand_req(1'b0, rand_sel(1'b0));
         bridge_do(req, 5, lat, rdt);
         check("o_brg_rdt", rdt, model_word(req.adr, req.sel));
         // Word stays on the bus after the ack
         check("o_brg_rdt", o_brg_rdt, model_word(req.adr, req.sel));
      end
      end_test(4, "bridge read");

      i_brg_mode = 1'b0;
      for (int i = 0; i < N_GATE; i++) begin
         req = rand_req($urandom % 2, rand_sel(1'b0));
         bridge_op(req, 10, got, lat, rdt);
         if (got) begin
            errors++;
            $display("Acknowledge seen in local mode for word %h", req.adr);
         end
         word_check(req.adr);
      end
      end_test(5, "mode gating");

      i_brg_mode = 1'b1;
      for (int i = 0; i < N_BRG; i++) begin
         req = rand_req($urandom % 2, rand_sel(1'b0));
         bridge_do(req, 10, lat, rdt);
         check("o_brg_ack latency", lat, exp_latency(req.we, req.sel));
         if (req.we) begin
            model_write(req);
         end else begin
            check("o_brg_rdt", rdt, model_word(req.adr, req.sel));
         end
      end
      end_test(6, "acknowledge latency");

      $display("Tests ok %0d of 6, checks %0d, errors %0d", tests_ok, checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sram_share_top.f
+incdir+verilog
verilog/sram_share_pkg.sv
verilog/byte_ram.sv
verilog/brg_write_slicer.sv
verilog/brg_read_gather.sv
verilog/ram_port_arbiter.sv
verilog/sram_share_top.sv
test/tb_sram_share.sv
